/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= alu_rs_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
+incdir+tests
src/alu_rs_pkg.sv
src/alu_issue_decode.sv
src/alu_station.sv
src/alu_execute.sv
src/alu_rs_top.sv
tests/alu_rs_tb.sv

/* src/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 exe_valid,
  input  alu_rs_pkg::exe_req_t exe,
  output alu_rs_pkg::cdb_t     result
);

  logic [31:0] alu_value;
  logic [4:0]  shamt;
  logic        lt_signed;
  logic        lt_unsigned;

  assign shamt       = exe.b[4:0];
  assign lt_signed   = $signed(exe.a) < $signed(exe.b);
  assign lt_unsigned = exe.a < exe.b;

  always_comb begin
    case (exe.op)
      alu_rs_pkg::alu_add:  alu_value = exe.a + exe.b;
      alu_rs_pkg::alu_sub:  alu_value = exe.a - exe.b;
      alu_rs_pkg::alu_sll:  alu_value = exe.a << shamt;
      alu_rs_pkg::alu_slt:  alu_value = {31'b0, lt_signed};
      alu_rs_pkg::alu_sltu: alu_value = {31'b0, lt_unsigned};
      alu_rs_pkg::alu_xor:  alu_value = exe.a ^ exe.b;
      alu_rs_pkg::alu_srl:  alu_value = exe.a >> shamt;
      // arithmetic shift keeps the sign bit
      alu_rs_pkg::alu_sra:  alu_value = $unsigned($signed(exe.a) >>> shamt);
      alu_rs_pkg::alu_or:   alu_value = exe.a | exe.b;
      alu_rs_pkg::alu_and:  alu_value = exe.a & exe.b;
      default:              alu_value = '0;
    endcase
  end

  // result register drives cdb lane 0
  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= exe_valid;
    end
    result.rob   <= exe.rob;
    result.value <= alu_value;
  end

endmodule

/* src/alu_issue_decode.sv */
`timescale 1ns/1ps

module alu_issue_decode (
  input  alu_rs_pkg::issue_req_t req,
  input  alu_rs_pkg::src_info_t  src1,
  input  alu_rs_pkg::src_info_t  src2,
  input  alu_rs_pkg::cdb_t       cdb [alu_rs_pkg::cdb_lanes],
  output alu_rs_pkg::rs_entry_t  entry
);

  // operand known at decode time, tag unused
  function automatic alu_rs_pkg::operand_t const_operand(input logic [31:0] value);
    alu_rs_pkg::operand_t opnd;
    opnd.ready = 1'b1;
    opnd.value = value;
    opnd.tag   = '0;
    return opnd;
  endfunction

  // regfile first, then rob, then a same-cycle broadcast
  function automatic alu_rs_pkg::operand_t resolve(
    input alu_rs_pkg::src_info_t src,
    input alu_rs_pkg::cdb_t      bus [alu_rs_pkg::cdb_lanes]
  );
    alu_rs_pkg::operand_t opnd;
    opnd.ready = 1'b0;
    opnd.value = '0;
    opnd.tag   = src.regfile_tag;
    if (src.regfile_ready) begin
      opnd.ready = 1'b1;
      opnd.value = src.regfile_value;
    end else if (src.rob_ready) begin
      opnd.ready = 1'b1;
      opnd.value = src.rob_value;
    end
    return alu_rs_pkg::snoop_cdb(opnd, bus);
  endfunction

  // funct3 to alu op; funct7[5] picks sub only for register form
  function automatic alu_rs_pkg::alu_op_e funct_op(
    input logic [2:0] funct3,
    input logic       alt,
    input logic       is_imm
  );
    alu_rs_pkg::alu_op_e op;
    case (funct3)
      3'b000:  op = (alt && !is_imm) ? alu_rs_pkg::alu_sub : alu_rs_pkg::alu_add;
      3'b001:  op = alu_rs_pkg::alu_sll;
      3'b010:  op = alu_rs_pkg::alu_slt;
      3'b011:  op = alu_rs_pkg::alu_sltu;
      3'b100:  op = alu_rs_pkg::alu_xor;
      3'b101:  op = alt ? alu_rs_pkg::alu_sra : alu_rs_pkg::alu_srl;
      3'b110:  op = alu_rs_pkg::alu_or;
      default: op = alu_rs_pkg::alu_and;
    endcase
    return op;
  endfunction

  always_comb begin
    entry.op  = alu_rs_pkg::alu_add;
    entry.rob = req.rob;
    entry.a   = resolve(src1, cdb);
    entry.b   = const_operand(req.imm);
    case (req.opcode)
      alu_rs_pkg::op_lui:   entry.a = const_operand(32'h0);
      alu_rs_pkg::op_auipc: entry.a = const_operand(req.pc);
      alu_rs_pkg::op_imm:   entry.op = funct_op(req.funct3, req.funct7[5], 1'b1);
      alu_rs_pkg::op_reg: begin
        entry.op = funct_op(req.funct3, req.funct7[5], 1'b0);
        entry.b  = resolve(src2, cdb);
      end
      default: begin
        // unknown opcodes fall back to rs1 + imm
      end
    endcase
  end

endmodule

/* src/alu_rs_pkg.sv */
package alu_rs_pkg;

  localparam int rob_tag_w  = 3;
  localparam int rs_entries = 8;
  localparam int rs_idx_w   = $clog2(rs_entries);
  // lane 0 is our own result, lane 1 comes from the other units
  localparam int cdb_lanes  = 2;

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv_opcode_e;

  typedef enum logic [3:0] {
    alu_add  = 4'h0,
    alu_sub  = 4'h1,
    alu_sll  = 4'h2,
    alu_slt  = 4'h3,
    alu_sltu = 4'h4,
    alu_xor  = 4'h5,
    alu_srl  = 4'h6,
    alu_sra  = 4'h7,
    alu_or   = 4'h8,
    alu_and  = 4'h9
  } alu_op_e;

  typedef struct packed {
    rv_opcode_e           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [31:0]          imm;
    logic [31:0]          pc;
    logic [rob_tag_w-1:0] rob;
  } issue_req_t;

  typedef struct packed {
    logic                 regfile_ready;
    logic [31:0]          regfile_value;
    logic [rob_tag_w-1:0] regfile_tag;
    logic                 rob_ready;
    logic [31:0]          rob_value;
  } src_info_t;

  typedef struct packed {
    logic                 ready;
    logic [31:0]          value;
    logic [rob_tag_w-1:0] tag;
  } operand_t;

  typedef struct packed {
    alu_op_e              op;
    operand_t             a;
    operand_t             b;
    logic [rob_tag_w-1:0] rob;
  } rs_entry_t;

  typedef struct packed {
    alu_op_e              op;
    logic [31:0]          a;
    logic [31:0]          b;
    logic [rob_tag_w-1:0] rob;
  } exe_req_t;

  typedef struct packed {
    logic                 valid;
    logic [rob_tag_w-1:0] rob;
    logic [31:0]          value;
  } cdb_t;

  // fill a waiting operand from any lane broadcasting its tag
  function automatic operand_t snoop_cdb(input operand_t opnd, input cdb_t bus [cdb_lanes]);
    operand_t res;
    res = opnd;
    for (int j = 0; j < cdb_lanes; j++) begin
      if (!res.ready && bus[j].valid && bus[j].rob == res.tag) begin
        res.ready = 1'b1;
        res.value = bus[j].value;
      end
    end
    return res;
  endfunction

endpackage

/* src/alu_rs_top.sv */
`timescale 1ns/1ps

module alu_rs_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue,
  input  alu_rs_pkg::issue_req_t req,
  input  alu_rs_pkg::src_info_t  src1,
  input  alu_rs_pkg::src_info_t  src2,
  input  alu_rs_pkg::cdb_t       ext_cdb,
  output logic                   full,
  output alu_rs_pkg::cdb_t       result
);

  alu_rs_pkg::cdb_t      cdb_bus [alu_rs_pkg::cdb_lanes];
  alu_rs_pkg::rs_entry_t dec_entry;
  alu_rs_pkg::exe_req_t  exe;
  logic                  exe_valid;

  // lane 0 own result, lane 1 other units
  assign cdb_bus[0] = result;
  assign cdb_bus[1] = ext_cdb;

  alu_issue_decode u_decode (
    .req   (req),
    .src1  (src1),
    .src2  (src2),
    .cdb   (cdb_bus),
    .entry (dec_entry)
  );

  alu_station u_station (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .entry_in  (dec_entry),
    .cdb       (cdb_bus),
    .full      (full),
    .exe_valid (exe_valid),
    .exe       (exe)
  );

  alu_execute u_execute (
    .clk       (clk),
    .rst       (rst),
    .exe_valid (exe_valid),
    .exe       (exe),
    .result    (result)
  );

endmodule

/* src/alu_station.sv */
`timescale 1ns/1ps

module alu_station (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue,
  input  alu_rs_pkg::rs_entry_t entry_in,
  input  alu_rs_pkg::cdb_t      cdb [alu_rs_pkg::cdb_lanes],
  output logic                  full,
  output logic                  exe_valid,
  output alu_rs_pkg::exe_req_t  exe
);

  logic [alu_rs_pkg::rs_entries-1:0] busy;
  alu_rs_pkg::rs_entry_t             slots [alu_rs_pkg::rs_entries];

  // round-robin pointer, last slot sent to execute
  logic [alu_rs_pkg::rs_idx_w-1:0] last_sel;
  logic [alu_rs_pkg::rs_idx_w-1:0] alloc_idx;
  logic [alu_rs_pkg::rs_idx_w-1:0] sel_idx;
  logic [alu_rs_pkg::rs_idx_w-1:0] cand;
  logic                            do_alloc;

  assign full     = &busy;
  assign do_alloc = issue && !full;

  // lowest free slot, walked top down so the lowest wins
  always_comb begin
    alloc_idx = '0;
    for (int i = alu_rs_pkg::rs_entries - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        alloc_idx = alu_rs_pkg::rs_idx_w'(i);
      end
    end
  end

  // search starts just after last_sel
  // walked from the far end so the nearest ready slot wins
  always_comb begin
    exe_valid = 1'b0;
    sel_idx   = last_sel;
    cand      = last_sel;
    for (int k = alu_rs_pkg::rs_entries; k >= 1; k--) begin
      cand = last_sel + alu_rs_pkg::rs_idx_w'(k);
      if (busy[cand] && slots[cand].a.ready && slots[cand].b.ready) begin
        exe_valid = 1'b1;
        sel_idx   = cand;
      end
    end
  end

  assign exe.op  = slots[sel_idx].op;
  assign exe.a   = slots[sel_idx].a.value;
  assign exe.b   = slots[sel_idx].b.value;
  assign exe.rob = slots[sel_idx].rob;

  // occupancy and pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= '0;
      last_sel <= '0;
    end else begin
      if (exe_valid) begin
        busy[sel_idx] <= 1'b0;
        last_sel      <= sel_idx;
      end
      if (do_alloc) begin
        busy[alloc_idx] <= 1'b1;
      end
    end
  end

  // entry payload: cdb wakeup, then new entry on top
  always_ff @(posedge clk) begin
    for (int i = 0; i < alu_rs_pkg::rs_entries; i++) begin
      if (busy[i]) begin
        slots[i].a <= alu_rs_pkg::snoop_cdb(slots[i].a, cdb);
        slots[i].b <= alu_rs_pkg::snoop_cdb(slots[i].b, cdb);
      end
    end
    // alloc slot is never busy, so no clash with the wakeup above
    if (do_alloc) begin
      slots[alloc_idx] <= entry_in;
    end
  end

endmodule

/* tests/alu_ref_model.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// source value: regfile first, then rob, else the broadcast it waits for
function automatic logic [31:0] pick_source(input alu_rs_pkg::src_info_t src,
                                            input logic [31:0] bcast);
  if (src.regfile_ready) begin
    return src.regfile_value;
  end
  if (src.rob_ready) begin
    return src.rob_value;
  end
  return bcast;
endfunction

// rv32i integer rules, alt is instruction bit 30
function automatic logic [31:0] rv32i_op(input logic [2:0] funct3, input logic alt,
                                         input logic [31:0] x, input logic [31:0] y);
  logic signed [31:0] sx;
  sx = x;
  case (funct3)
    3'd0: return alt ? x - y : x + y;
    3'd1: return x << y[4:0];
    3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    3'd3: return (x < y) ? 32'd1 : 32'd0;
    3'd4: return x ^ y;
    3'd5: begin
      if (alt) begin
        return sx >>> y[4:0];
      end
      return x >> y[4:0];
    end
    3'd6: return x | y;
    default: return x & y;
  endcase
endfunction

function automatic logic [31:0] expected_result(input alu_rs_pkg::issue_req_t req,
                                                input logic [31:0] rs1,
                                                input logic [31:0] rs2);
  case (req.opcode)
    alu_rs_pkg::op_lui:   return req.imm;
    alu_rs_pkg::op_auipc: return req.pc + req.imm;
    // no subi, bit 30 only picks srai
    alu_rs_pkg::op_imm:
      return rv32i_op(req.funct3, req.funct7[5] && req.funct3 == 3'd5, rs1, req.imm);
    default:              return rv32i_op(req.funct3, req.funct7[5], rs1, rs2);
  endcase
endfunction

`endif

/* tests/alu_rs_tb.sv */
`timescale 1ns/1ps

module alu_rs_tb;

  `include "alu_ref_model.svh"

  localparam int num_tests = 6;
  localparam int never     = 32'h7fff_ffff;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   issue;
  alu_rs_pkg::issue_req_t req;
  alu_rs_pkg::src_info_t  src1;
  alu_rs_pkg::src_info_t  src2;
  alu_rs_pkg::cdb_t       ext_cdb;
  logic                   full;
  alu_rs_pkg::cdb_t       result;

  logic [31:0] rng = 32'h31b5;
  logic [31:0] expected [8];
  int          earliest [8];
  int          issued_cnt [8];
  int          returned_cnt [8];
  int          cyc = 0;
  int          mon_errors = 0;
  int          seq_errors = 0;
  int          failed_tests = 0;

  alu_rs_top DUT (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // result lane sampled mid cycle
  always @(negedge clk) begin
    if (!rst && result.valid) begin
      assert (issued_cnt[result.rob] > returned_cnt[result.rob]) else begin
        $display("tag %0d returned twice or was never issued", result.rob);
        mon_errors++;
      end
      assert (result.value == expected[result.rob]) else begin
        $display("FAILED result.value tag %0d expected %h got %h",
                 result.rob, expected[result.rob], result.value);
        mon_errors++;
      end
      assert (cyc >= earliest[result.rob]) else begin
        $display("tag %0d came out in cycle %0d before its wakeup", result.rob, cyc);
        mon_errors++;
      end
      returned_cnt[result.rob]++;
    end
  end

  // 2000 cycles per test
  initial begin
    #(num_tests * 2000 * 8);
    $display("watchdog expired at cycle %0d", cyc);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic int outstanding();
    int n = 0;
    for (int t = 0; t < 8; t++) begin
      if (issued_cnt[t] != returned_cnt[t]) begin
        n++;
      end
    end
    return n;
  endfunction

  // ready sources come from regfile or rob
  // the stale rob value checks priority
  function automatic alu_rs_pkg::src_info_t make_src(input logic [31:0] value,
                                                     input logic [2:0] tag,
                                                     input logic waiting);
    alu_rs_pkg::src_info_t s;
    logic [31:0] r;
    r = xorshift32();
    s.regfile_ready = !waiting && r[0];
    s.regfile_value = r[0] ? value : ~value;
    s.regfile_tag   = tag;
    s.rob_ready     = !waiting && (!r[0] || r[4]);
    s.rob_value     = r[0] ? ~value : value;
    return s;
  endfunction

  task automatic set_req(input alu_rs_pkg::rv_opcode_e opcode, input logic [2:0] funct3,
                         input logic alt, input int tag);
    req.opcode = opcode;
    req.funct3 = funct3;
    req.funct7 = {1'b0, alt, 5'b0};
    req.imm    = xorshift32();
    req.pc     = xorshift32();
    req.rob    = 3'(tag);
  endtask

  task automatic random_reg(input int tag);
    logic [31:0] r;
    r = xorshift32();
    set_req(alu_rs_pkg::op_reg, r[2:0], r[3], tag);
  endtask

  // bcast values stand in for sources that wait on a tag
  task automatic send(input logic [31:0] bcast1, input logic [31:0] bcast2,
                      input logic woken_later);
    while (full) begin
      step();
    end
    issue = 1'b1;
    expected[req.rob] = expected_result(req, pick_source(src1, bcast1),
                                        pick_source(src2, bcast2));
    earliest[req.rob] = woken_later ? never : cyc + 2;
    issued_cnt[req.rob]++;
    step();
    issue = 1'b0;
  endtask

  task automatic set_ext(input logic valid, input logic [2:0] tag, input logic [31:0] value);
    ext_cdb.valid = valid;
    ext_cdb.rob   = tag;
    ext_cdb.value = value;
  endtask

  task automatic random_ops(input alu_rs_pkg::rv_opcode_e opcode, input int count);
    for (int i = 0; i < count; i++) begin
      set_req(opcode, i[2:0], i[3], i % 8);
      src1 = make_src(xorshift32(), 3'd0, 1'b0);
      src2 = make_src(xorshift32(), 3'd0, 1'b0);
      send('0, '0, 1'b0);
    end
  endtask

  // wait for every issued tag, then report the test
  task automatic finish_test(input string name, input int errs_before);
    int waited;
    waited = 0;
    while (outstanding() != 0 && waited < 200) begin
      step();
      waited++;
    end
    assert (outstanding() == 0) else begin
      $display("%s: %0d tags never returned", name, outstanding());
      seq_errors++;
    end
    if (mon_errors + seq_errors == errs_before) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail", name);
      failed_tests++;
    end
  endtask

  initial begin
    logic [31:0] v [4];
    int errs;
    int waited;
    rst = 1'b1;
    issue = 1'b0;
    req = '0;
    src1 = '0;
    src2 = '0;
    ext_cdb = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    step();

    errs = mon_errors + seq_errors;
    random_ops(alu_rs_pkg::op_lui, 8);
    random_ops(alu_rs_pkg::op_auipc, 8);
    finish_test("lui_auipc", errs);

    errs = mon_errors + seq_errors;
    random_ops(alu_rs_pkg::op_imm, 32);
    finish_test("op_imm", errs);

    errs = mon_errors + seq_errors;
    random_ops(alu_rs_pkg::op_reg, 32);
    finish_test("op_reg", errs);

    // broadcast in the issue cycle is caught by decode
    errs = mon_errors + seq_errors;
    for (int i = 0; i < 4; i++) begin
      v[i] = xorshift32();
      random_reg(4 + i);
      src1 = make_src(xorshift32(), 3'd0, 1'b0);
      src2 = make_src('0, 3'(i), 1'b1);
      set_ext(1'b1, 3'(i), v[i]);
      send('0, v[i], 1'b0);
    end
    set_ext(1'b0, 3'd0, '0);
    repeat (4) step();
    // entries wait on tags 4..7 from other units
    for (int i = 0; i < 4; i++) begin
      v[i] = xorshift32();
      random_reg(i);
      src1 = make_src('0, 3'(4 + i), 1'b1);
      src2 = make_src(xorshift32(), 3'd0, 1'b0);
      send(v[i], '0, 1'b1);
    end
    repeat (6) step();
    for (int i = 0; i < 4; i++) begin
      earliest[i] = cyc + 2;
      set_ext(1'b1, 3'(4 + i), v[i]);
      step();
    end
    set_ext(1'b0, 3'd0, '0);
    finish_test("ext_wakeup", errs);

    // each link waits on the previous result from lane 0
    errs = mon_errors + seq_errors;
    for (int i = 0; i < 6; i++) begin
      random_reg(i);
      src1 = make_src(xorshift32(), 3'(i + 7), i != 0);
      src2 = make_src(xorshift32(), 3'd0, 1'b0);
      send((i == 0) ? 32'd0 : expected[(i + 7) % 8], '0, 1'b0);
    end
    finish_test("dependency_chain", errs);

    errs = mon_errors + seq_errors;
    v[0] = xorshift32();
    for (int i = 0; i < 8; i++) begin
      assert (!full) else begin
        $display("full high with only %0d entries issued", i);
        seq_errors++;
      end
      random_reg(i);
      src1 = make_src('0, 3'd7, 1'b1);
      src2 = make_src(xorshift32(), 3'd0, 1'b0);
      send(v[0], '0, 1'b1);
    end
    for (int i = 0; i < 4; i++) begin
      assert (full) else begin
        $display("full low in cycle %0d with all entries waiting", cyc);
        seq_errors++;
      end
      step();
    end
    for (int i = 0; i < 8; i++) begin
      earliest[i] = cyc + 2;
    end
    set_ext(1'b1, 3'd7, v[0]);
    step();
    set_ext(1'b0, 3'd0, '0);
    waited = 0;
    while (full && waited < 4) begin
      step();
      waited++;
    end
    assert (!full) else begin
      $display("full still high %0d cycles after the wakeup", waited);
      seq_errors++;
    end
    finish_test("full_and_wakeup", errs);

    $display("%0d tests, %0d failed, %0d errors", num_tests, failed_tests,
             mon_errors + seq_errors);
    if (mon_errors + seq_errors == 0 && failed_tests == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
